// ==== files.f ====
source/memPkg.sv
source/memArbiter.sv
source/memStatus.sv
source/memArray.sv
source/memCtrl.sv
source/memSubsys.sv
verif/memSubsysTb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
# Exit status is nonzero when the log reports a failure
rm -rf obj_dir sim.log
verilator --binary --timing --top-module memSubsysTb -f files.f -o memSubsysSim \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/memSubsysSim > sim.log 2>&1 || echo "Simulator exited abnormally" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Test failed"; exit 1; } || true
grep -q "NO ERRORS" sim.log && echo "Test passed" || { echo "No verdict in log"; exit 1; }

// ==== source/memArbiter.sv ====
////////////////////////////////////////
// Round-robin arbiter for the CPU and console ports
////////////////////////////////////////

`timescale 1ns/1ps

module memArbiter
(
   input  logic clk,
   input  logic rst,
   // Request levels from the two masters
   input  logic cpuReq,
   input  logic conReq,
   // End of access from the controller
   input  logic done,
   // Held grants, one-hot or both low
   output logic grantCpu,
   output logic grantCon,
   // One-cycle kick to the controller
   output logic start
);

   // Set while an access is in flight
   logic busy;

   // Last master served was the CPU
   logic lastCpu;

   // Winner of the current round
   logic pickCpu;
   logic pickCon;

   ////////////////////////////////////////
   // Round-robin pick
   ////////////////////////////////////////

   // Console wins when alone, or when both ask and the CPU went last
   // CPU wins every other case where it is requesting
   always_comb
   begin
      pickCon = conReq & (~cpuReq | lastCpu);
      pickCpu = cpuReq & ~pickCon;
   end

   ////////////////////////////////////////
   // Grant and start registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         grantCpu <= 1'b0;
         grantCon <= 1'b0;
         start    <= 1'b0;
         // Console counts as last served so the CPU wins the first tie
         lastCpu  <= 1'b0;
      end
      else
      begin
         // Start lasts a single cycle
         start <= 1'b0;
         if (busy)
         begin
            // Drop grant after done so a released request is not granted again
            if (done)
            begin
               busy     <= 1'b0;
               grantCpu <= 1'b0;
               grantCon <= 1'b0;
            end
         end
         else if (cpuReq || conReq)
         begin
            busy     <= 1'b1;
            start    <= 1'b1;
            grantCpu <= pickCpu;
            grantCon <= pickCon;
            lastCpu  <= pickCpu;
         end
      end
   end

endmodule

// ==== source/memArray.sv ====
////////////////////////////////////////
// Word storage, synchronous write, registered read
////////////////////////////////////////

`timescale 1ns/1ps

module memArray
(
   input  logic                             clk,
   // Write enable for the addressed word
   input  logic                             arrWe,
   // Word index, upper address bits already dropped
   input  logic [memPkg::MEM_ADDR_BITS-1:0] arrAddr,
   input  memPkg::word36                    arrWdata,
   // Data from the address of the previous cycle
   output memPkg::word36                    arrRdata
);

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   // One entry per word, contents undefined until written
   memPkg::word36 mem [0:memPkg::MEM_DEPTH-1];

   // Write lands at the clock edge
   always_ff @(posedge clk)
   begin
      if (arrWe)
      begin
         mem[arrAddr] <= arrWdata;
      end
   end

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Registered read, one cycle after the address
   // A write to the same word in the same cycle returns the old contents
   always_ff @(posedge clk)
   begin
      arrRdata <= mem[arrAddr];
   end

endmodule

// ==== source/memCtrl.sv ====
////////////////////////////////////////
// Memory controller sequencer
// Decodes memory or IO space, drives array and MSR, returns data
////////////////////////////////////////

`timescale 1ns/1ps

module memCtrl
(
   input  logic                             clk,
   input  logic                             rst,
   // Kick from the arbiter, fields below are valid in this cycle
   input  logic                             start,
   input  logic                             write,
   input  logic                             io,
   input  memPkg::addr20                    addr,
   input  memPkg::word36                    wdata,
   // Read paths from the array and the status register
   input  memPkg::word36                    arrRdata,
   input  memPkg::word36                    regStat,
   // Array port
   output logic                             arrWe,
   output logic [memPkg::MEM_ADDR_BITS-1:0] arrAddr,
   output memPkg::word36                    arrWdata,
   // Status register port
   output logic                             msrWrite,
   output memPkg::word36                    msrWdata,
   // End of access and returned data
   output logic                             done,
   output memPkg::word36                    rdata
);

   // Sequencer state
   memPkg::ctrlState state;
   memPkg::ctrlState nextState;

   // Request fields captured at start
   logic          writeQ;
   logic          ioQ;
   memPkg::addr20 addrQ;
   memPkg::word36 wdataQ;

   // IO access hits the status register
   logic msrHit;

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   // Two cycles busy after start, then back to idle
   always_comb
   begin
      nextState = state;
      unique case (state)
         memPkg::IDLE:
         begin
            if (start)
            begin
               nextState = memPkg::ACCESS;
            end
         end
         memPkg::ACCESS:
         begin
            nextState = memPkg::DONE;
         end
         memPkg::DONE:
         begin
            nextState = memPkg::IDLE;
         end
         default:
         begin
            nextState = memPkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= memPkg::IDLE;
      end
      else
      begin
         state <= nextState;
      end
   end

   // Hold the request while the access runs
   always_ff @(posedge clk)
   begin
      if (start && state == memPkg::IDLE)
      begin
         writeQ <= write;
         ioQ    <= io;
         addrQ  <= addr;
         wdataQ <= wdata;
      end
   end

   ////////////////////////////////////////
   // Access strobes
   ////////////////////////////////////////

   assign msrHit = (addrQ == memPkg::MSR_IO_ADDR);

   // Address is presented every cycle, a read only needs it in ACCESS
   assign arrAddr  = addrQ[memPkg::MEM_ADDR_BITS-1:0];
   assign arrWdata = wdataQ;
   assign arrWe    = (state == memPkg::ACCESS) & ~ioQ & writeQ;

   // Writes to other IO addresses go nowhere
   assign msrWdata = wdataQ;
   assign msrWrite = (state == memPkg::ACCESS) & ioQ & writeQ & msrHit;

   ////////////////////////////////////////
   // Completion and read data
   ////////////////////////////////////////

   assign done = (state == memPkg::DONE);

   // Array data arrives from the registered read issued in ACCESS
   // Writes and unused IO addresses return zero
   always_comb
   begin
      rdata = '0;
      if (done && !writeQ)
      begin
         if (!ioQ)
         begin
            rdata = arrRdata;
         end
         else if (msrHit)
         begin
            rdata = regStat;
         end
      end
   end

endmodule

// ==== source/memPkg.sv ====
////////////////////////////////////////
// Shared types and constants for the memory subsystem
// Word and address typedefs, array depth, MSR bit map, controller states
////////////////////////////////////////

package memPkg;

   ////////////////////////////////////////
   // Data and address types
   ////////////////////////////////////////

   // 36-bit machine word
   // Bit 0 is the most significant bit, as in the processor documentation
   typedef logic [0:35] word36;

   // Physical or IO address
   // Ordinary little-endian numbering so the low bits can slice the array index
   typedef logic [19:0] addr20;

   ////////////////////////////////////////
   // Memory array geometry
   ////////////////////////////////////////

   // Only the low address bits select a word
   // Anything above bit 9 aliases onto the same storage
   localparam int MEM_ADDR_BITS = 10;

   // Number of words held by the array
   localparam int MEM_DEPTH = 1 << MEM_ADDR_BITS;

   ////////////////////////////////////////
   // Memory Status Register
   ////////////////////////////////////////

   // IO address of the status register, octal 100000
   localparam addr20 MSR_IO_ADDR = 20'o100000;

   // Field positions within word36, documentation numbering
   //
   //   0    EH   error hold, reads zero
   //   1    UE   uncorrectable error, reads zero
   //   2    RE   refresh error, reads zero
   //   3    PE   parity error, read/write
   //   4    EE   ECC enable, reads inverse of last ED written
   //   12   PF   power fail, set at reset, write zero to clear
   //   30   FCB  force check bits, ignored here
   //   35   ED   ECC disable, write only
   //
   // Only the four positions below matter to this design
   localparam int MSR_PE_BIT = 3;
   localparam int MSR_EE_BIT = 4;
   localparam int MSR_PF_BIT = 12;
   localparam int MSR_ED_BIT = 35;

   ////////////////////////////////////////
   // Controller sequencer
   ////////////////////////////////////////

   // IDLE waits for start from the arbiter
   // ACCESS drives the array or MSR strobes
   // DONE returns data and pulses done
   typedef enum logic [1:0]
   {
      IDLE   = 2'd0,
      ACCESS = 2'd1,
      DONE   = 2'd2
   } ctrlState;

endpackage

// ==== source/memStatus.sv ====
////////////////////////////////////////
// Memory Status Register with PE, PF and EE bits
////////////////////////////////////////

`timescale 1ns/1ps

module memStatus
(
   input  logic          clk,
   input  logic          rst,
   // Write strobe and data from the controller
   input  logic          msrWrite,
   input  memPkg::word36 msrWdata,
   // Current register contents in read layout
   output memPkg::word36 regStat
);

   // Parity error flag, plain read/write
   logic statPe;

   // Power fail flag
   logic statPf;

   // ECC enable, kept as the inverse of ED
   logic statEe;

   ////////////////////////////////////////
   // Register updates
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         statPe <= 1'b0;
         // Power-up leaves PF set until software acknowledges it
         statPf <= 1'b1;
         // ECC starts enabled
         statEe <= 1'b1;
      end
      else if (msrWrite)
      begin
         statPe <= msrWdata[memPkg::MSR_PE_BIT];
         // Writing one keeps PF, writing zero clears it for good
         statPf <= statPf & msrWdata[memPkg::MSR_PF_BIT];
         statEe <= ~msrWdata[memPkg::MSR_ED_BIT];
      end
   end

   ////////////////////////////////////////
   // Read-back word
   ////////////////////////////////////////

   // EH, UE, RE, ECP, ERA and FCB all read as zero
   always_comb
   begin
      regStat                     = '0;
      regStat[memPkg::MSR_PE_BIT] = statPe;
      regStat[memPkg::MSR_EE_BIT] = statEe;
      regStat[memPkg::MSR_PF_BIT] = statPf;
   end

endmodule

// ==== source/memSubsys.sv ====
////////////////////////////////////////
// Memory subsystem top level
// Two master ports, arbiter, controller, array, status register
////////////////////////////////////////

`timescale 1ns/1ps

module memSubsys
(
   input  logic          clk,
   input  logic          rst,
   // CPU port
   input  logic          cpuReq,
   input  logic          cpuWrite,
   input  logic          cpuIo,
   input  memPkg::addr20 cpuAddr,
   input  memPkg::word36 cpuWdata,
   output logic          cpuAck,
   // Console port
   input  logic          conReq,
   input  logic          conWrite,
   input  logic          conIo,
   input  memPkg::addr20 conAddr,
   input  memPkg::word36 conWdata,
   output logic          conAck,
   // Shared read data, valid with an acknowledge
   output memPkg::word36 rdata
);

   // Arbiter to controller
   logic grantCpu;
   logic grantCon;
   logic start;
   logic done;

   // Granted request fields
   logic          reqWrite;
   logic          reqIo;
   memPkg::addr20 reqAddr;
   memPkg::word36 reqWdata;

   // Array port
   logic                             arrWe;
   logic [memPkg::MEM_ADDR_BITS-1:0] arrAddr;
   memPkg::word36                    arrWdata;
   memPkg::word36                    arrRdata;

   // Status register port
   logic          msrWrite;
   memPkg::word36 msrWdata;
   memPkg::word36 regStat;

   ////////////////////////////////////////
   // Master selection
   ////////////////////////////////////////

   memArbiter uArbiter
   (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .conReq   (conReq),
      .done     (done),
      .grantCpu (grantCpu),
      .grantCon (grantCon),
      .start    (start)
   );

   // Grant holds for the whole access, so the mux is stable
   assign reqWrite = grantCon ? conWrite : cpuWrite;
   assign reqIo    = grantCon ? conIo    : cpuIo;
   assign reqAddr  = grantCon ? conAddr  : cpuAddr;
   assign reqWdata = grantCon ? conWdata : cpuWdata;

   // Done goes back only to the master holding the grant
   assign cpuAck = done & grantCpu;
   assign conAck = done & grantCon;

   ////////////////////////////////////////
   // Controller and targets
   ////////////////////////////////////////

   memCtrl uCtrl
   (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .write    (reqWrite),
      .io       (reqIo),
      .addr     (reqAddr),
      .wdata    (reqWdata),
      .arrRdata (arrRdata),
      .regStat  (regStat),
      .arrWe    (arrWe),
      .arrAddr  (arrAddr),
      .arrWdata (arrWdata),
      .msrWrite (msrWrite),
      .msrWdata (msrWdata),
      .done     (done),
      .rdata    (rdata)
   );

   memArray uArray
   (
      .clk      (clk),
      .arrWe    (arrWe),
      .arrAddr  (arrAddr),
      .arrWdata (arrWdata),
      .arrRdata (arrRdata)
   );

   memStatus uStatus
   (
      .clk      (clk),
      .rst      (rst),
      .msrWrite (msrWrite),
      .msrWdata (msrWdata),
      .regStat  (regStat)
   );

endmodule

// ==== verif/memSubsysTb.sv ====
////////////////////////////////////////
// Testbench for the memory subsystem
// Stimulus table, contention phase, reference model, watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module memSubsysTb;

   // One access, with its expected read data
   typedef struct packed
   {
      logic          isCon;
      logic          write;
      logic          io;
      memPkg::addr20 addr;
      memPkg::word36 wdata;
      memPkg::word36 expData;
      logic          check;
   } accessEntry;

   logic clk;
   logic rst;

   // Master ports
   logic          cpuReq;
   logic          cpuWrite;
   logic          cpuIo;
   memPkg::addr20 cpuAddr;
   memPkg::word36 cpuWdata;
   logic          cpuAck;
   logic          conReq;
   logic          conWrite;
   logic          conIo;
   memPkg::addr20 conAddr;
   memPkg::word36 conWdata;
   logic          conAck;
   memPkg::word36 rdata;

   // Result counters
   int errors = 0;
   int checks = 0;

   // Stimulus table and per-master random streams
   accessEntry tbl[$];
   accessEntry cpuOps[$];
   accessEntry conOps[$];
   int randOps = 24;
   logic [31:0] rngState = 32'h8460c142;

   // Reference model of the array and the three status bits
   memPkg::word36 refMem [0:memPkg::MEM_DEPTH-1];
   logic modPe = 1'b0;
   logic modPf = 1'b1;
   logic modEe = 1'b1;

   // Acknowledge monitor state
   logic contention = 1'b0;
   logic prevCpuAck = 1'b0;
   logic prevConAck = 1'b0;
   logic lastAckCon = 1'b0;
   logic haveLastAck = 1'b0;
   int cpuAckCount = 0;
   int conAckCount = 0;

   memSubsys u_dut
   (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .cpuWrite (cpuWrite),
      .cpuIo    (cpuIo),
      .cpuAddr  (cpuAddr),
      .cpuWdata (cpuWdata),
      .cpuAck   (cpuAck),
      .conReq   (conReq),
      .conWrite (conWrite),
      .conIo    (conIo),
      .conAddr  (conAddr),
      .conWdata (conWdata),
      .conAck   (conAck),
      .rdata    (rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Xorshift generator, state kept in rngState
   function automatic logic [31:0] nextRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   // Status word as read back, all other fields zero
   function automatic memPkg::word36 statusWord(input logic pe, input logic ee, input logic pf);
      memPkg::word36 w;
      w = '0;
      w[memPkg::MSR_PE_BIT] = pe;
      w[memPkg::MSR_EE_BIT] = ee;
      w[memPkg::MSR_PF_BIT] = pf;
      return w;
   endfunction

   function automatic accessEntry makeEntry(input logic isCon, input logic write, input logic io,
      input memPkg::addr20 addr, input memPkg::word36 wdata, input memPkg::word36 expData);
      accessEntry e;
      e.isCon   = isCon;
      e.write   = write;
      e.io      = io;
      e.addr    = addr;
      e.wdata   = wdata;
      e.expData = expData;
      // Writes return zero data, so every entry is compared
      e.check   = 1'b1;
      return e;
   endfunction

   // Random access, each master owns one half of the array
   function automatic accessEntry randomOp(input logic isCon, input logic haveWr,
      input memPkg::addr20 lastWr);
      accessEntry e;
      logic [31:0] r;
      logic [31:0] hi;
      r = nextRandom();
      hi = nextRandom();
      e.isCon   = isCon;
      e.expData = '0;
      e.wdata   = {hi[3:0], nextRandom()};
      if (r[3:0] < 4'd2)
      begin
         // Occasional status register access
         e.io    = 1'b1;
         e.write = r[4];
         e.addr  = memPkg::MSR_IO_ADDR;
      end
      else
      begin
         e.io    = 1'b0;
         e.write = r[5] | ~haveWr;
         // Reads revisit the last written word, upper bits random so they alias
         e.addr  = e.write ? r[31:12] : {r[31:22], lastWr[memPkg::MEM_ADDR_BITS-1:0]};
         e.addr[memPkg::MEM_ADDR_BITS-1] = isCon;
      end
      e.check = ~e.write;
      return e;
   endfunction

   // Expected read data from the model
   function automatic memPkg::word36 expectedRead(input accessEntry e);
      if (!e.io)
      begin
         return refMem[e.addr[memPkg::MEM_ADDR_BITS-1:0]];
      end
      else if (e.addr == memPkg::MSR_IO_ADDR)
      begin
         return statusWord(modPe, modEe, modPf);
      end
      return '0;
   endfunction

   // Apply the write rules to the model once the access is acknowledged
   task automatic updateModel(input accessEntry e);
      if (e.write && !e.io)
      begin
         refMem[e.addr[memPkg::MEM_ADDR_BITS-1:0]] = e.wdata;
      end
      else if (e.write && e.addr == memPkg::MSR_IO_ADDR)
      begin
         modPe = e.wdata[memPkg::MSR_PE_BIT];
         modPf = modPf & e.wdata[memPkg::MSR_PF_BIT];
         modEe = ~e.wdata[memPkg::MSR_ED_BIT];
      end
   endtask

   // Raise the request, then wait for this master's acknowledge
   task automatic doAccess(input accessEntry e, output memPkg::word36 got, output int cycles);
      logic ack;
      ack = 1'b0;
      cycles = 0;
      got = '0;
      @(posedge clk);
      if (e.isCon)
      begin
         conReq   <= 1'b1;
         conWrite <= e.write;
         conIo    <= e.io;
         conAddr  <= e.addr;
         conWdata <= e.wdata;
      end
      else
      begin
         cpuReq   <= 1'b1;
         cpuWrite <= e.write;
         cpuIo    <= e.io;
         cpuAddr  <= e.addr;
         cpuWdata <= e.wdata;
      end
      while (!ack && cycles < 20)
      begin
         @(negedge clk);
         cycles++;
         ack = e.isCon ? conAck : cpuAck;
      end
      if (!ack)
      begin
         errors++;
         $display("No acknowledge for %s access to address %h within 20 cycles",
            e.isCon ? "console" : "CPU", e.addr);
      end
      else
      begin
         got = rdata;
         updateModel(e);
      end
   endtask

   task automatic dropRequest(input logic isCon);
      @(posedge clk);
      if (isCon)
      begin
         conReq <= 1'b0;
      end
      else
      begin
         cpuReq <= 1'b0;
      end
   endtask

   // One master's random stream, requests stay up back to back
   task automatic runOps(input logic isCon);
      accessEntry op;
      memPkg::word36 got;
      memPkg::word36 expData;
      int cycles;
      int n;
      n = isCon ? conOps.size() : cpuOps.size();
      for (int i = 0; i < n; i++)
      begin
         op = isCon ? conOps[i] : cpuOps[i];
         doAccess(op, got, cycles);
         expData = expectedRead(op);
         if (op.check)
         begin
            checks++;
            if (got !== expData)
            begin
               errors++;
               $display("MISMATCH rdata %s op %0d addr %h expected %h got %h",
                  isCon ? "console" : "CPU", i, op.addr, expData, got);
            end
         end
      end
      dropRequest(isCon);
   endtask

   ////////////////////////////////////////
   // Acknowledge monitor
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (cpuAck && conAck)
         begin
            errors++;
            $display("Both masters acknowledged in the same cycle");
         end
         if ((cpuAck && !cpuReq) || (conAck && !conReq))
         begin
            errors++;
            $display("Acknowledge to a master with no request pending");
         end
         if ((cpuAck && prevCpuAck) || (conAck && prevConAck))
         begin
            errors++;
            $display("Acknowledge held for more than one cycle");
         end
         // Under contention the grants must alternate while both still ask
         if (contention && (cpuAck || conAck))
         begin
            if (haveLastAck && lastAckCon == conAck
               && (conAck ? cpuAckCount : conAckCount) < randOps)
            begin
               errors++;
               $display("Same master granted twice in a row under contention");
            end
            cpuAckCount += cpuAck ? 1 : 0;
            conAckCount += conAck ? 1 : 0;
            lastAckCon  = conAck;
            haveLastAck = 1'b1;
         end
      end
      prevCpuAck = cpuAck;
      prevConAck = conAck;
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      memPkg::word36 got;
      memPkg::word36 ignoredBits;
      int cycles;
      int limitCycles;
      logic haveWr [0:1];
      memPkg::addr20 lastWr [0:1];
      accessEntry op;

      rst      <= 1'b1;
      cpuReq   <= 1'b0;
      cpuWrite <= 1'b0;
      cpuIo    <= 1'b0;
      cpuAddr  <= '0;
      cpuWdata <= '0;
      conReq   <= 1'b0;
      conWrite <= 1'b0;
      conIo    <= 1'b0;
      conAddr  <= '0;
      conWdata <= '0;

      // EH, UE, RE and FCB at 0, 1, 2 and 30, plus PF written as one
      ignoredBits = '0;
      ignoredBits[0] = 1'b1;
      ignoredBits[1] = 1'b1;
      ignoredBits[2] = 1'b1;
      ignoredBits[30] = 1'b1;
      ignoredBits[memPkg::MSR_PF_BIT] = 1'b1;

      // Status register after reset, then the write rules
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b1, memPkg::MSR_IO_ADDR, '0,
         statusWord(1'b0, 1'b1, 1'b1)));
      tbl.push_back(makeEntry(1'b0, 1'b1, 1'b1, memPkg::MSR_IO_ADDR, '1, '0));
      tbl.push_back(makeEntry(1'b1, 1'b0, 1'b1, memPkg::MSR_IO_ADDR, '0,
         statusWord(1'b1, 1'b0, 1'b1)));
      tbl.push_back(makeEntry(1'b1, 1'b1, 1'b1, memPkg::MSR_IO_ADDR, '0, '0));
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b1, memPkg::MSR_IO_ADDR, '0,
         statusWord(1'b0, 1'b1, 1'b0)));
      tbl.push_back(makeEntry(1'b0, 1'b1, 1'b1, memPkg::MSR_IO_ADDR, ignoredBits, '0));
      tbl.push_back(makeEntry(1'b1, 1'b0, 1'b1, memPkg::MSR_IO_ADDR, '0,
         statusWord(1'b0, 1'b1, 1'b0)));
      // Array words, 00053 and 00453 alias as do 003ff and fffff
      tbl.push_back(makeEntry(1'b0, 1'b1, 1'b0, 20'h00053, 36'h123456789, '0));
      tbl.push_back(makeEntry(1'b1, 1'b0, 1'b0, 20'h00053, '0, 36'h123456789));
      tbl.push_back(makeEntry(1'b1, 1'b1, 1'b0, 20'h00453, 36'hABCDEF012, '0));
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b0, 20'h00053, '0, 36'hABCDEF012));
      tbl.push_back(makeEntry(1'b1, 1'b1, 1'b0, 20'h003ff, 36'h0F0F0F0F0, '0));
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b0, 20'hfffff, '0, 36'h0F0F0F0F0));
      // Unused IO space reads zero and swallows writes
      // Octal 100123 shares its low bits with word 00053
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b1, 20'o100001, '0, '0));
      tbl.push_back(makeEntry(1'b1, 1'b1, 1'b1, 20'o100123, '1, '0));
      tbl.push_back(makeEntry(1'b1, 1'b0, 1'b0, 20'h00053, '0, 36'hABCDEF012));
      tbl.push_back(makeEntry(1'b0, 1'b0, 1'b1, memPkg::MSR_IO_ADDR, '0,
         statusWord(1'b0, 1'b1, 1'b0)));

      // Random streams built up front so the contention run is repeatable
      haveWr[0] = 1'b0;
      haveWr[1] = 1'b0;
      lastWr[0] = '0;
      lastWr[1] = '0;
      for (int i = 0; i < randOps; i++)
      begin
         for (int m = 0; m < 2; m++)
         begin
            op = randomOp(m[0], haveWr[m], lastWr[m]);
            if (!op.io && op.write)
            begin
               haveWr[m] = 1'b1;
               lastWr[m] = op.addr;
            end
            if (m == 0)
            begin
               cpuOps.push_back(op);
            end
            else
            begin
               conOps.push_back(op);
            end
         end
      end

      // Watchdog sized from the table and the random phase
      limitCycles = tbl.size() * 20 + 2 * randOps * 40 + 8;
      fork
         begin
            repeat (limitCycles) @(posedge clk);
            $display("Watchdog expired after %0d cycles, the test did not finish", limitCycles);
            $display("Checks: %0d  Errors: %0d", checks, errors + 1);
            $display("ERRORS FOUND");
            $finish;
         end
      join_none

      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Table phase, one master at a time
      for (int i = 0; i < tbl.size(); i++)
      begin
         doAccess(tbl[i], got, cycles);
         dropRequest(tbl[i].isCon);
         checks++;
         if (cycles - 1 != 3)
         begin
            errors++;
            $display("Entry %0d acknowledged %0d cycles after the request was sampled, not 3",
               i, cycles - 1);
         end
         if (tbl[i].check)
         begin
            checks++;
            if (got !== tbl[i].expData)
            begin
               errors++;
               $display("MISMATCH rdata entry %0d expected %h got %h", i, tbl[i].expData, got);
            end
         end
      end

      // Contention phase, both masters request without gaps
      contention = 1'b1;
      fork
         runOps(1'b0);
         runOps(1'b1);
      join
      contention = 1'b0;
      checks++;
      if (cpuAckCount != randOps || conAckCount != randOps)
      begin
         errors++;
         $display("Acknowledge count wrong, CPU %0d and console %0d for %0d requests each",
            cpuAckCount, conAckCount, randOps);
      end

      repeat (4) @(posedge clk);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
